/* bench/rover_tb.sv */
`timescale 1ns/1ps
`include "rover_consts.svh"

module rover_tb;
    import rover_pkg::*;

    localparam int HOLD = 2 * `PWM_PERIOD + 8;    // Room for a full PWM window check
    localparam int GAP = 4;
    localparam int N_RANDOM = 300;
    localparam int N_FLOOD = 80;
    localparam int DRAIN = 8;
    localparam int STIM_CYCLES = 16 + HOLD + 8 * (1 + GAP) + 12 * (1 + HOLD) + (1 + GAP)
                                 + N_RANDOM + N_FLOOD + DRAIN;
    localparam int TIMEOUT_CYCLES = 3 * STIM_CYCLES + 200;

    logic clk_50 = 1'b0;
    logic reset;
    logic ir_push;
    ir_event_t ir_data;
    logic ir_credit;
    logic cam_push;
    cam_report_t cam_data;
    logic cam_credit;
    rover_status_t status;
    wheel_t left_wheel;
    wheel_t right_wheel;
    logic [7:0][6:0] hex;

    integer seed;
    int ir_credits;
    int cam_credits;
    int ir_push_count = 0;
    int cam_push_count = 0;
    int ir_pulse_count = 0;
    int cam_pulse_count = 0;
    int cycle_count = 0;
    int stable_cycles = 0;
    logic checking = 1'b0;                         // Set once reset is released
    rover_status_t exp_status;
    rover_status_t prev_status = '0;
    cam_report_t held_report;
    ir_event_t ir_model_q[$];
    cam_report_t cam_model_q[$];
    logic [`PWM_PERIOD-1:0] left_hist = '0;        // Last PWM_PERIOD pwm samples
    logic [`PWM_PERIOD-1:0] right_hist = '0;

    rover_top rover_top_i (
        .clk_50(clk_50),
        .reset(reset),
        .ir_push(ir_push),
        .ir_data(ir_data),
        .ir_credit(ir_credit),
        .cam_push(cam_push),
        .cam_data(cam_data),
        .cam_credit(cam_credit),
        .status(status),
        .left_wheel(left_wheel),
        .right_wheel(right_wheel),
        .hex(hex)
    );

    always #4 clk_50 = ~clk_50;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Expected next status from the mode, track and command rules
    function automatic rover_status_t next_status(input rover_status_t cur, input logic got_ir,
                                                  input logic [7:0] code,
                                                  input cam_report_t rep);
        rover_status_t nxt;
        nxt = cur;
        if (got_ir) begin
            if (code == `BTN_CAM && cur.mode != MODE_CAM) begin
                nxt.mode = MODE_CAM;
            end else if (code == `BTN_IR && cur.mode != MODE_IR) begin
                nxt.mode = MODE_IR;
            end else if (code == `BTN_IDLE && cur.mode != MODE_IDLE) begin
                nxt.mode = MODE_IDLE;
            end
        end
        if (nxt.mode != MODE_CAM) begin
            nxt.track = TRK_PAUSE;
        end else if (cur.track == TRK_PAUSE) begin
            nxt.track = TRK_SEARCH;                // Just entered camera mode
        end else begin
            nxt.track = rep.target_seen ? TRK_FOLLOW : TRK_SEARCH;
        end
        nxt.cmd = CMD_STOP;
        if (nxt.track == TRK_SEARCH) begin
            nxt.cmd = CMD_RIGHT;
        end else if (nxt.track == TRK_FOLLOW) begin
            if (rep.bearing == 3'd1) begin
                nxt.cmd = CMD_LEFT;
            end else if (rep.bearing == 3'd2) begin
                nxt.cmd = CMD_RIGHT;
            end else if (rep.bearing == 3'd3 && rep.speed_class == 2'd0) begin
                nxt.cmd = CMD_SLOW;
            end else if (rep.bearing == 3'd3 && rep.speed_class == 2'd1) begin
                nxt.cmd = CMD_MEDIUM;
            end else if (rep.bearing == 3'd3 && rep.speed_class == 2'd2) begin
                nxt.cmd = CMD_FAST;
            end
        end
        return nxt;
    endfunction

    // Active-low segments, bit 0 is a
    function automatic logic [6:0] segments_for(input logic [7:0] c);
        case (c)
            "A": return 7'b0001000;
            "C": return 7'b1000110;
            "d": return 7'b0100001;
            "E": return 7'b0000110;
            "F": return 7'b0001110;
            "G": return 7'b1000010;
            "H": return 7'b0001001;
            "I": return 7'b1111001;
            "L": return 7'b1000111;
            "n": return 7'b0101011;
            "O": return 7'b1000000;
            "P": return 7'b0001100;
            "r": return 7'b0101111;
            "S": return 7'b0010010;
            "t": return 7'b0000111;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic [7:0][6:0] expected_digits(input rover_status_t s);
        string mode_txt;
        string trk_txt;
        string cmd_txt;
        string text;
        logic [7:0][6:0] digits;
        mode_txt = (s.mode == MODE_CAM) ? "CA" : (s.mode == MODE_IR) ? "Ir" : "Id";
        trk_txt = (s.track == TRK_SEARCH) ? "S" : (s.track == TRK_FOLLOW) ? "F" : "P";
        case (s.cmd)
            CMD_LEFT: cmd_txt = "LEFt";
            CMD_RIGHT: cmd_txt = "rGHt";
            CMD_SLOW: cmd_txt = "SLO ";
            CMD_MEDIUM: cmd_txt = "nEd ";
            CMD_FAST: cmd_txt = "FASt";
            default: cmd_txt = "StOP";
        endcase
        text = {mode_txt, " ", trk_txt, cmd_txt};
        for (int i = 0; i < 8; i++) begin
            digits[7 - i] = segments_for(text[i]);   // Leftmost character on digit 7
        end
        return digits;
    endfunction

    function automatic int wheel_duty(input drive_cmd_t cmd);
        case (cmd)
            CMD_LEFT, CMD_RIGHT: return `DUTY_TURN;
            CMD_SLOW: return `DUTY_SLOW;
            CMD_MEDIUM: return `DUTY_MEDIUM;
            CMD_FAST: return `DUTY_FAST;
            default: return 0;
        endcase
    endfunction

    function automatic logic wheel_reverse(input drive_cmd_t cmd, input logic is_left);
        return (cmd == CMD_LEFT && is_left) || (cmd == CMD_RIGHT && !is_left);
    endfunction

    task automatic check_status(input rover_status_t got, input rover_status_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf(
                "ERROR at %0t: status mode/track/cmd %0d/%0d/%0d, expected %0d/%0d/%0d",
                $time, got.mode, got.track, got.cmd, exp.mode, exp.track, exp.cmd));
        end
    endtask

    task automatic check_hex(input logic [7:0][6:0] got, input logic [7:0][6:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR at %0t: display %h, expected %h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_wheel(input string side, input wheel_t got, input logic exp_reverse,
                               input int high_cycles, input int exp_duty);
        if (got.reverse !== exp_reverse || high_cycles != exp_duty) begin
            stop_with_failure($sformatf(
                "ERROR at %0t: %s wheel reverse %b high %0d, expected reverse %b high %0d",
                $time, side, got.reverse, high_cycles, exp_reverse, exp_duty));
        end
    endtask

    // One falling-edge step, a push only goes out with a credit in hand
    task automatic drive_cycle(input logic want_ir, input ir_event_t ir, input logic want_cam,
                               input cam_report_t cam, output logic ir_done,
                               output logic cam_done);
        @(negedge clk_50);
        if (ir_credit) ir_credits++;
        if (cam_credit) cam_credits++;
        ir_done = want_ir && (ir_credits > 0);
        cam_done = want_cam && (cam_credits > 0);
        ir_push = ir_done;
        ir_data = ir;
        cam_push = cam_done;
        cam_data = cam;
        if (ir_done) ir_credits--;
        if (cam_done) cam_credits--;
    endtask

    task automatic send_items(input logic want_ir, input ir_event_t ir, input logic want_cam,
                              input cam_report_t cam);
        logic ir_left;
        logic cam_left;
        logic ir_done;
        logic cam_done;
        ir_left = want_ir;
        cam_left = want_cam;
        do begin
            drive_cycle(ir_left, ir, cam_left, cam, ir_done, cam_done);
            if (ir_done) ir_left = 1'b0;
            if (cam_done) cam_left = 1'b0;
        end while (ir_left || cam_left);
    endtask

    task automatic idle_cycles(input int n);
        logic ir_done;
        logic cam_done;
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, ir_done, cam_done);
    endtask

    task automatic press_button(input logic [7:0] code, input int hold);
        send_items(1'b1, ir_event_t'{code: code}, 1'b0, '0);
        idle_cycles(hold);
    endtask

    task automatic show_report(input logic seen, input logic [2:0] bearing,
                               input logic [1:0] speed);
        send_items(1'b0, '0, 1'b1, cam_report_t'{target_seen: seen, bearing: bearing,
                                                  speed_class: speed});
        idle_cycles(HOLD);
    endtask

    task automatic random_cycle(input logic flood);
        logic [31:0] r;
        logic [31:0] d;
        ir_event_t ir;
        cam_report_t cam;
        logic ir_done;
        logic cam_done;
        r = $random(seed);
        d = $random(seed);
        case (r[9:8])                              // Mostly real buttons
            2'd0: ir.code = `BTN_CAM;
            2'd1: ir.code = `BTN_IR;
            2'd2: ir.code = `BTN_IDLE;
            default: ir.code = d[7:0];
        endcase
        cam = cam_report_t'{target_seen: d[8], bearing: d[11:9], speed_class: d[13:12]};
        drive_cycle(flood || r[12:10] == 3'd0, ir, flood || r[13], cam, ir_done, cam_done);
    endtask

    // Reference model steps on the same edge as the DUT
    always @(posedge clk_50) begin : model_step
        ir_event_t ir_head;
        logic got_ir;
        if (reset) begin
            checking = 1'b0;
            exp_status = '{mode: MODE_IDLE, track: TRK_PAUSE, cmd: CMD_STOP};
            held_report = '0;
            ir_model_q.delete();
            cam_model_q.delete();
        end else begin
            got_ir = (ir_model_q.size() > 0);
            ir_head = got_ir ? ir_model_q.pop_front() : '0;
            if (cam_model_q.size() > 0) held_report = cam_model_q.pop_front();
            exp_status = next_status(exp_status, got_ir, ir_head.code, held_report);
            if (ir_push) begin
                ir_model_q.push_back(ir_data);
                ir_push_count++;
            end
            if (cam_push) begin
                cam_model_q.push_back(cam_data);
                cam_push_count++;
            end
            if (ir_push_count - ir_pulse_count > `QUEUE_DEPTH ||
                cam_push_count - cam_pulse_count > `QUEUE_DEPTH) begin
                stop_with_failure("A producer pushed more entries than it had credits for");
            end
            checking = 1'b1;
        end
    end

    always @(negedge clk_50) begin : compare_step
        int duty;
        if (checking) begin
            if (ir_credit) ir_pulse_count++;
            if (cam_credit) cam_pulse_count++;
            if (ir_pulse_count > ir_push_count || cam_pulse_count > cam_push_count) begin
                stop_with_failure("A credit pulse came back with no matching push");
            end
            check_status(status, exp_status);
            check_hex(hex, expected_digits(exp_status));
            stable_cycles = (exp_status !== prev_status) ? 0 : stable_cycles + 1;
            prev_status = exp_status;
            left_hist = {left_hist[`PWM_PERIOD-2:0], left_wheel.pwm};
            right_hist = {right_hist[`PWM_PERIOD-2:0], right_wheel.pwm};
            if (stable_cycles >= 2 * `PWM_PERIOD) begin
                duty = wheel_duty(exp_status.cmd);
                check_wheel("left", left_wheel, wheel_reverse(exp_status.cmd, 1'b1),
                            $countones(left_hist), duty);
                check_wheel("right", right_wheel, wheel_reverse(exp_status.cmd, 1'b0),
                            $countones(right_hist), duty);
            end
        end
    end

    always @(posedge clk_50) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout, the run did not finish within %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    initial begin
        seed = 32'h664f;
        reset = 1'b1;
        ir_push = 1'b0;
        ir_data = '0;
        cam_push = 1'b0;
        cam_data = '0;
        ir_credits = `QUEUE_DEPTH;
        cam_credits = `QUEUE_DEPTH;
        repeat (16) @(posedge clk_50);
        @(negedge clk_50);
        reset = 1'b0;
        idle_cycles(HOLD);                         // Idle, pause, stop and quiet wheels

        press_button(8'h55, GAP);                  // Unknown code in idle
        press_button(`BTN_IR, GAP);
        press_button(8'h42, GAP);                  // Unknown code in IR mode
        press_button(`BTN_CAM, GAP);
        press_button(`BTN_IR, GAP);
        press_button(`BTN_IDLE, GAP);
        press_button(`BTN_CAM, GAP);
        press_button(`BTN_IDLE, GAP);

        press_button(`BTN_CAM, HOLD);              // Search spins right
        show_report(1'b1, 3'd1, 2'd0);
        show_report(1'b1, 3'd3, 2'd0);
        show_report(1'b1, 3'd3, 2'd1);
        show_report(1'b1, 3'd3, 2'd2);
        show_report(1'b1, 3'd2, 2'd0);
        show_report(1'b1, 3'd3, 2'd3);             // Bad speed class stops
        show_report(1'b0, 3'd0, 2'd0);             // Target lost
        show_report(1'b1, 3'd3, 2'd2);
        press_button(`BTN_IR, HOLD);
        press_button(`BTN_CAM, HOLD);              // Held report brings back follow
        press_button(`BTN_IDLE, HOLD);

        press_button(`BTN_CAM, GAP);
        repeat (N_RANDOM) random_cycle(1'b0);
        repeat (N_FLOOD) random_cycle(1'b1);       // Both producers at full rate
        idle_cycles(DRAIN);
        @(posedge clk_50);
        if (ir_pulse_count == ir_push_count && cam_pulse_count == cam_push_count) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_with_failure($sformatf(
                "ERROR at %0t: credit pulses ir %0d cam %0d, pushes ir %0d cam %0d",
                $time, ir_pulse_count, cam_pulse_count, ir_push_count, cam_push_count));
        end
    end

endmodule

/* include/rover_consts.svh */
`ifndef ROVER_CONSTS_SVH
`define ROVER_CONSTS_SVH

// IR remote button codes
`define BTN_CAM 8'h0f
`define BTN_IR 8'h13
`define BTN_IDLE 8'h10

// Entries per input queue, also the producer's starting credit
`define QUEUE_DEPTH 4

// PWM period in clk_50 cycles
`define PWM_PERIOD 16

// High cycles per PWM period
`define DUTY_SLOW 4
`define DUTY_MEDIUM 8
`define DUTY_FAST 12
`define DUTY_TURN 8

`endif

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module rover_tb -o rover_sim &&
{ sim_out=$(./obj_dir/rover_sim 2>&1); printf '%s\n' "$sim_out"; } &&
printf '%s\n' "$sim_out" | grep -qF "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

/* sources.f */
+incdir+include
src/rover_pkg.sv
src/credit_queue.sv
src/mode_controller.sv
src/motor_driver.sv
src/status_display.sv
src/rover_top.sv
bench/rover_tb.sv

/* src/credit_queue.sv */
`timescale 1ns/1ps

module credit_queue #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 4
) (
    input logic clk_50,
    input logic reset,
    input logic push,
    input payload_t push_data,
    input logic pop,
    output payload_t head,
    output logic not_empty,
    output logic credit
);
    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    payload_t mem [depth];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic full;
    logic wr_en;
    logic rd_en;

    // Pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(depth));
    assign not_empty = (count != '0);
    assign wr_en = push && !full;      // Producer credit keeps this from ever dropping
    assign rd_en = pop && not_empty;
    assign head = mem[rd_ptr];

    always_ff @(posedge clk_50) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= rd_en;               // One credit back per popped entry
        end
    end

endmodule

/* src/mode_controller.sv */
`timescale 1ns/1ps
`include "rover_consts.svh"

module mode_controller (
    input logic clk_50,
    input logic reset,
    input logic ir_valid,
    input rover_pkg::ir_event_t ir_event,
    output logic ir_pop,
    input logic cam_valid,
    input rover_pkg::cam_report_t cam_report,
    output logic cam_pop,
    output rover_pkg::rover_status_t status,
    output logic restart
);
    import rover_pkg::*;

    cam_report_t last_report;
    cam_report_t report;
    mode_t next_mode;
    track_t next_track;
    drive_cmd_t next_cmd;

    // Every non-empty queue is drained each cycle
    assign ir_pop = ir_valid;
    assign cam_pop = cam_valid;

    assign report = cam_valid ? cam_report : last_report;

    // Mode follows the IR button when one arrives
    always_comb begin
        next_mode = status.mode;
        if (ir_valid) begin
            case (status.mode)
                MODE_IDLE: begin
                    if (ir_event.code == `BTN_CAM) begin
                        next_mode = MODE_CAM;
                    end else if (ir_event.code == `BTN_IR) begin
                        next_mode = MODE_IR;
                    end
                end
                MODE_CAM: begin
                    if (ir_event.code == `BTN_IR) begin
                        next_mode = MODE_IR;
                    end else if (ir_event.code == `BTN_IDLE) begin
                        next_mode = MODE_IDLE;
                    end
                end
                MODE_IR: begin
                    if (ir_event.code == `BTN_CAM) begin
                        next_mode = MODE_CAM;
                    end else if (ir_event.code == `BTN_IDLE) begin
                        next_mode = MODE_IDLE;
                    end
                end
                default: next_mode = MODE_IDLE;
            endcase
        end
    end

    // Tracking sub-machine runs only in camera mode
    always_comb begin
        if (next_mode != MODE_CAM) begin
            next_track = TRK_PAUSE;
        end else begin
            case (status.track)
                TRK_SEARCH, TRK_FOLLOW: next_track = report.target_seen ? TRK_FOLLOW : TRK_SEARCH;
                default: next_track = TRK_SEARCH;    // Entering camera mode
            endcase
        end
    end

    always_comb begin
        next_cmd = CMD_STOP;
        if (next_track == TRK_SEARCH) begin
            next_cmd = CMD_RIGHT;                    // Spin to look for the target
        end else if (next_track == TRK_FOLLOW) begin
            case (report.bearing)
                3'd1: next_cmd = CMD_LEFT;
                3'd2: next_cmd = CMD_RIGHT;
                3'd3: begin                          // Straight ahead
                    case (report.speed_class)
                        2'd0: next_cmd = CMD_SLOW;
                        2'd1: next_cmd = CMD_MEDIUM;
                        2'd2: next_cmd = CMD_FAST;
                        default: next_cmd = CMD_STOP;
                    endcase
                end
                default: next_cmd = CMD_STOP;
            endcase
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            status <= '{mode: MODE_IDLE, track: TRK_PAUSE, cmd: CMD_STOP};
            restart <= 1'b0;
            last_report <= '0;
        end else begin
            status <= '{mode: next_mode, track: next_track, cmd: next_cmd};
            restart <= (next_mode != status.mode) || (next_track != status.track);
            last_report <= report;
        end
    end

endmodule

/* src/motor_driver.sv */
`timescale 1ns/1ps
`include "rover_consts.svh"

module motor_driver (
    input logic clk_50,
    input logic reset,
    input rover_pkg::rover_status_t status,
    input logic restart,
    output rover_pkg::wheel_t left_wheel,
    output rover_pkg::wheel_t right_wheel
);
    import rover_pkg::*;

    localparam int CNT_W = $clog2(`PWM_PERIOD);
    localparam int DUTY_W = $clog2(`PWM_PERIOD + 1);

    logic [CNT_W-1:0] period_cnt;
    logic [DUTY_W-1:0] left_duty;
    logic [DUTY_W-1:0] right_duty;
    logic left_rev;
    logic right_rev;
    logic [DUTY_W-1:0] next_left_duty;
    logic [DUTY_W-1:0] next_right_duty;
    logic next_left_rev;
    logic next_right_rev;

    // Command to per-wheel duty and direction
    always_comb begin
        next_left_duty = '0;
        next_right_duty = '0;
        next_left_rev = 1'b0;
        next_right_rev = 1'b0;
        case (status.cmd)
            CMD_LEFT: begin
                next_left_duty = DUTY_W'(`DUTY_TURN);
                next_right_duty = DUTY_W'(`DUTY_TURN);
                next_left_rev = 1'b1;                // Pivot in place
            end
            CMD_RIGHT: begin
                next_left_duty = DUTY_W'(`DUTY_TURN);
                next_right_duty = DUTY_W'(`DUTY_TURN);
                next_right_rev = 1'b1;
            end
            CMD_SLOW: begin
                next_left_duty = DUTY_W'(`DUTY_SLOW);
                next_right_duty = DUTY_W'(`DUTY_SLOW);
            end
            CMD_MEDIUM: begin
                next_left_duty = DUTY_W'(`DUTY_MEDIUM);
                next_right_duty = DUTY_W'(`DUTY_MEDIUM);
            end
            CMD_FAST: begin
                next_left_duty = DUTY_W'(`DUTY_FAST);
                next_right_duty = DUTY_W'(`DUTY_FAST);
            end
            default: ;                               // Stop
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (reset || restart) begin
            period_cnt <= '0;                        // Realign period on state change
        end else if (period_cnt == CNT_W'(`PWM_PERIOD - 1)) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            left_duty <= '0;
            right_duty <= '0;
            left_rev <= 1'b0;
            right_rev <= 1'b0;
        end else begin
            left_duty <= next_left_duty;
            right_duty <= next_right_duty;
            left_rev <= next_left_rev;
            right_rev <= next_right_rev;
        end
    end

    assign left_wheel.pwm = DUTY_W'(period_cnt) < left_duty;
    assign left_wheel.reverse = left_rev;
    assign right_wheel.pwm = DUTY_W'(period_cnt) < right_duty;
    assign right_wheel.reverse = right_rev;

endmodule

/* src/rover_pkg.sv */
package rover_pkg;

    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_CAM = 2'd1,
        MODE_IR = 2'd2
    } mode_t;

    typedef enum logic [1:0] {
        TRK_SEARCH = 2'd0,
        TRK_FOLLOW = 2'd1,
        TRK_PAUSE = 2'd3
    } track_t;

    typedef enum logic [2:0] {
        CMD_STOP = 3'd0,
        CMD_LEFT = 3'd1,
        CMD_RIGHT = 3'd2,
        CMD_SLOW = 3'd3,
        CMD_MEDIUM = 3'd4,
        CMD_FAST = 3'd5
    } drive_cmd_t;

    typedef struct packed {
        logic [7:0] code;           // Raw button code from the remote
    } ir_event_t;

    typedef struct packed {
        logic target_seen;          // Orange target in view
        logic [2:0] bearing;        // 1 left, 2 right, 3 ahead
        logic [1:0] speed_class;    // 0 slow, 1 medium, 2 fast
    } cam_report_t;

    typedef struct packed {
        logic pwm;
        logic reverse;
    } wheel_t;

    typedef struct packed {
        mode_t mode;
        track_t track;
        drive_cmd_t cmd;
    } rover_status_t;

endpackage

/* src/rover_top.sv */
`timescale 1ns/1ps
`include "rover_consts.svh"

module rover_top (
    input logic clk_50,
    input logic reset,
    input logic ir_push,
    input rover_pkg::ir_event_t ir_data,
    output logic ir_credit,
    input logic cam_push,
    input rover_pkg::cam_report_t cam_data,
    output logic cam_credit,
    output rover_pkg::rover_status_t status,
    output rover_pkg::wheel_t left_wheel,
    output rover_pkg::wheel_t right_wheel,
    output logic [7:0][6:0] hex
);
    import rover_pkg::*;

    ir_event_t ir_head;
    logic ir_not_empty;
    logic ir_pop;
    cam_report_t cam_head;
    logic cam_not_empty;
    logic cam_pop;
    logic restart;

    credit_queue #(
        .payload_t(ir_event_t),
        .depth(`QUEUE_DEPTH)
    ) u_ir_queue (
        .clk_50(clk_50),
        .reset(reset),
        .push(ir_push),
        .push_data(ir_data),
        .pop(ir_pop),
        .head(ir_head),
        .not_empty(ir_not_empty),
        .credit(ir_credit)
    );

    credit_queue #(
        .payload_t(cam_report_t),
        .depth(`QUEUE_DEPTH)
    ) u_cam_queue (
        .clk_50(clk_50),
        .reset(reset),
        .push(cam_push),
        .push_data(cam_data),
        .pop(cam_pop),
        .head(cam_head),
        .not_empty(cam_not_empty),
        .credit(cam_credit)
    );

    mode_controller u_ctrl (
        .clk_50(clk_50),
        .reset(reset),
        .ir_valid(ir_not_empty),
        .ir_event(ir_head),
        .ir_pop(ir_pop),
        .cam_valid(cam_not_empty),
        .cam_report(cam_head),
        .cam_pop(cam_pop),
        .status(status),
        .restart(restart)
    );

    motor_driver u_motor (
        .clk_50(clk_50),
        .reset(reset),
        .status(status),
        .restart(restart),
        .left_wheel(left_wheel),
        .right_wheel(right_wheel)
    );

    status_display u_display (
        .status(status),
        .hex(hex)
    );

endmodule

/* src/status_display.sv */
`timescale 1ns/1ps

module status_display (
    input rover_pkg::rover_status_t status,
    output logic [7:0][6:0] hex
);
    import rover_pkg::*;

    // Active-low segments, bit 0 is segment a, bit 6 is segment g
    localparam logic [6:0] G_BLANK = 7'b1111111;
    localparam logic [6:0] G_A = 7'b0001000;
    localparam logic [6:0] G_C = 7'b1000110;
    localparam logic [6:0] G_D = 7'b0100001;     // Lower case d
    localparam logic [6:0] G_E = 7'b0000110;
    localparam logic [6:0] G_F = 7'b0001110;
    localparam logic [6:0] G_G = 7'b1000010;
    localparam logic [6:0] G_H = 7'b0001001;
    localparam logic [6:0] G_I = 7'b1111001;
    localparam logic [6:0] G_L = 7'b1000111;
    localparam logic [6:0] G_N = 7'b0101011;     // Lower case n, stands in for M
    localparam logic [6:0] G_O = 7'b1000000;
    localparam logic [6:0] G_P = 7'b0001100;
    localparam logic [6:0] G_R = 7'b0101111;     // Lower case r
    localparam logic [6:0] G_S = 7'b0010010;
    localparam logic [6:0] G_T = 7'b0000111;     // Lower case t

    always_comb begin
        case (status.mode)
            MODE_CAM: begin
                hex[7] = G_C;
                hex[6] = G_A;
            end
            MODE_IR: begin
                hex[7] = G_I;
                hex[6] = G_R;
            end
            default: begin
                hex[7] = G_I;
                hex[6] = G_D;
            end
        endcase

        hex[5] = G_BLANK;

        case (status.track)
            TRK_SEARCH: hex[4] = G_S;
            TRK_FOLLOW: hex[4] = G_F;
            default: hex[4] = G_P;
        endcase

        // Command word, digit 3 is leftmost
        case (status.cmd)
            CMD_LEFT: hex[3:0] = {G_L, G_E, G_F, G_T};
            CMD_RIGHT: hex[3:0] = {G_R, G_G, G_H, G_T};
            CMD_SLOW: hex[3:0] = {G_S, G_L, G_O, G_BLANK};
            CMD_MEDIUM: hex[3:0] = {G_N, G_E, G_D, G_BLANK};
            CMD_FAST: hex[3:0] = {G_F, G_A, G_S, G_T};
            default: hex[3:0] = {G_S, G_T, G_O, G_P};
        endcase
    end

endmodule
